// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    typedef logic [XLEN-1:0] u_int_x;
    typedef logic [31:0]     addr_t;
    typedef logic [7:0]      iid_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;

    localparam iid_t IID_NONE = 8'hFF; // Reserved, never issued.

    localparam csr_addr_t CSR_SCRATCH = 12'h340;
    localparam csr_addr_t CSR_INSTRET = 12'hC02;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC  = 2'd2,
        WB_CSR = 2'd3
    } wb_sel_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        PASS_B = 4'd10  // LUI style immediate.
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_READ  = 2'd1,
        CSR_WRITE = 2'd2
    } csr_op_e;

    typedef struct packed {
        wb_sel_e  wb_sel;
        logic     rf_wen;
        reg_idx_t wb_addr;
        alu_op_e  alu_op;
        mem_op_e  mem_op;
        csr_op_e  csr_op;
        logic     src2_imm;
    } ctrl_t;

    typedef struct packed {
        addr_t     pc;
        iid_t      inst_id;
        ctrl_t     ctrl;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        u_int_x    imm;
        csr_addr_t csr_addr;
    } uop_t;

    typedef struct packed {
        addr_t  pc;
        iid_t   inst_id;
        ctrl_t  ctrl;
        u_int_x alu_out;
        u_int_x store_data;
        u_int_x csr_rdata;
    } ex_mem_t;

    typedef struct packed {
        addr_t  pc;
        iid_t   inst_id;
        ctrl_t  ctrl;
        u_int_x alu_out;
        u_int_x mem_rdata;
        u_int_x csr_rdata;
    } mem_wb_t;

    typedef struct packed {
        addr_t    pc;
        iid_t     inst_id;
        reg_idx_t rd;
        logic     wen;
        u_int_x   data;
    } retire_t;

    // Result source selection, shared by memory forwarding and write-back.
    function automatic u_int_x wb_select(
        input addr_t   pc,
        input wb_sel_e wb_sel,
        input u_int_x  alu_out,
        input u_int_x  mem_rdata,
        input u_int_x  csr_rdata
    );
        case (wb_sel)
            WB_MEM:  return mem_rdata;
            WB_PC:   return pc + 32'd4;
            WB_CSR:  return csr_rdata;
            default: return alu_out;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     issue_valid,
    input  wire uop_t     issue_uop,
    input  wire u_int_x   regfile [NREGS],
    input  wire logic     mem_fwd_wen,
    input  wire reg_idx_t mem_fwd_rd,
    input  wire u_int_x   mem_fwd_data,
    input  wire logic     wb_fwd_wen,
    input  wire reg_idx_t wb_fwd_rd,
    input  wire u_int_x   wb_fwd_data,
    output csr_op_e       csr_op,
    output csr_addr_t     csr_addr,
    output u_int_x        csr_wdata,
    input  wire u_int_x   csr_rdata,
    output logic          ex_valid,
    output ex_mem_t       ex_mem
);

    logic   uop_valid;
    uop_t   uop_q;
    u_int_x rs1_val;
    u_int_x rs2_val;
    u_int_x op_b;
    u_int_x alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) uop_q <= issue_uop;
    end

    // Youngest producer wins.
    function automatic u_int_x forward(input reg_idx_t idx);
        if (idx == '0) return '0;
        if (mem_fwd_wen && mem_fwd_rd == idx) return mem_fwd_data;
        if (wb_fwd_wen && wb_fwd_rd == idx) return wb_fwd_data;
        return regfile[idx];
    endfunction

    always_comb begin
        rs1_val = forward(uop_q.rs1);
        rs2_val = forward(uop_q.rs2);
    end

    assign op_b = uop_q.ctrl.src2_imm ? uop_q.imm : rs2_val;

    always_comb begin
        case (uop_q.ctrl.alu_op)
            ADD:     alu_out = rs1_val + op_b;
            SUB:     alu_out = rs1_val - op_b;
            AND:     alu_out = rs1_val & op_b;
            OR:      alu_out = rs1_val | op_b;
            XOR:     alu_out = rs1_val ^ op_b;
            SLL:     alu_out = rs1_val << op_b[4:0];
            SRL:     alu_out = rs1_val >> op_b[4:0];
            SRA:     alu_out = u_int_x'($signed(rs1_val) >>> op_b[4:0]);
            SLT:     alu_out = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            SLTU:    alu_out = {{(XLEN-1){1'b0}}, rs1_val < op_b};
            PASS_B:  alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    assign csr_op    = uop_valid ? uop_q.ctrl.csr_op : CSR_NONE;
    assign csr_addr  = uop_q.csr_addr;
    assign csr_wdata = rs1_val; // Operand A.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            ex_mem.pc         <= uop_q.pc;
            ex_mem.inst_id    <= uop_q.inst_id;
            ex_mem.ctrl       <= uop_q.ctrl;
            ex_mem.alu_out    <= alu_out;
            ex_mem.store_data <= rs2_val;
            ex_mem.csr_rdata  <= csr_rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import core_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    ex_valid,
    input  wire ex_mem_t ex_mem,
    output logic         mem_fwd_wen,
    output reg_idx_t     mem_fwd_rd,
    output u_int_x       mem_fwd_data,
    output logic         mem_valid,
    output mem_wb_t      mem_wb
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    u_int_x            dmem [DMEM_WORDS];
    logic [XLEN-3:0]   word_addr;
    logic [IDX_W-1:0]  ram_idx;
    u_int_x            mem_rdata;
    iid_t              last_id;
    logic              mem_new;

    assign word_addr = ex_mem.alu_out[XLEN-1:2];
    assign ram_idx   = IDX_W'(word_addr % DMEM_WORDS);
    assign mem_rdata = dmem[ram_idx]; // Combinational load.

    // Same duplicate filter as write-back, one stage earlier.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_id <= IID_NONE;
        end else if (ex_valid) begin
            last_id <= ex_mem.inst_id;
        end
    end

    assign mem_new = ex_valid && (ex_mem.inst_id != last_id);

    always_ff @(posedge clk) begin
        if (mem_new && ex_mem.ctrl.mem_op == MEM_STORE) dmem[ram_idx] <= ex_mem.store_data;
    end

    assign mem_fwd_wen  = mem_new && ex_mem.ctrl.rf_wen && (ex_mem.ctrl.wb_addr != '0);
    assign mem_fwd_rd   = ex_mem.ctrl.wb_addr;
    assign mem_fwd_data = wb_select(ex_mem.pc, ex_mem.ctrl.wb_sel, ex_mem.alu_out,
                                    mem_rdata, ex_mem.csr_rdata);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            mem_wb.pc        <= ex_mem.pc;
            mem_wb.inst_id   <= ex_mem.inst_id;
            mem_wb.ctrl      <= ex_mem.ctrl;
            mem_wb.alu_out   <= ex_mem.alu_out;
            mem_wb.mem_rdata <= mem_rdata;
            mem_wb.csr_rdata <= ex_mem.csr_rdata;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && ex_mem.ctrl.mem_op != MEM_NONE |-> ex_mem.alu_out[1:0] == 2'b00)
        else $error("misaligned data access at %h", ex_mem.alu_out);

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire csr_op_e   csr_op,
    input  wire csr_addr_t csr_addr,
    input  wire u_int_x    csr_wdata,
    output u_int_x         csr_rdata,
    input  wire logic      retire_pulse,
    output u_int_x         instret
);

    u_int_x scratch;

    always_comb begin
        case (csr_addr)
            CSR_INSTRET: csr_rdata = instret;
            CSR_SCRATCH: csr_rdata = scratch;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= '0;
        end else if (retire_pulse) begin
            instret <= instret + 1'b1; // Once per retired id.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (csr_op == CSR_WRITE && csr_addr == CSR_SCRATCH) begin
            scratch <= csr_wdata;
        end
    end

    // Upstream decode must never send a write to the counter.
    a_no_instret_write: assert property (@(posedge clk) disable iff (!rst_n)
        csr_op == CSR_WRITE |-> csr_addr != CSR_INSTRET)
        else $error("CSR write to read-only instret");

endmodule

`default_nettype wire

// File: verilog/write_back_stage.sv
`timescale 1ns/1ns
`default_nettype none

module write_back_stage import core_pkg::*; #(
    parameter u_int_x STACK_TOP = 32'h00007500
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    mem_valid,
    input  wire mem_wb_t mem_wb,
    output u_int_x       regfile [NREGS],
    output logic         wb_fwd_wen,
    output reg_idx_t     wb_fwd_rd,
    output u_int_x       wb_wdata_out,
    output logic         retire_pulse,
    output logic         retire_valid,
    output retire_t      retire
);

    u_int_x wb_data;
    iid_t   saved_inst_id;
    logic   is_new_inst;
    logic   rd_wen;

    assign wb_data = wb_select(mem_wb.pc, mem_wb.ctrl.wb_sel, mem_wb.alu_out,
                               mem_wb.mem_rdata, mem_wb.csr_rdata);
    assign wb_wdata_out = wb_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_inst_id <= IID_NONE;
        end else if (mem_valid) begin
            saved_inst_id <= mem_wb.inst_id;
        end
    end

    // A held micro-op keeps its id and retires only on the first cycle.
    assign is_new_inst = mem_valid && (mem_wb.inst_id != saved_inst_id);
    assign rd_wen      = mem_wb.ctrl.rf_wen && (mem_wb.ctrl.wb_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regfile[i] <= '1;
            end
            regfile[0] <= '0;
            regfile[2] <= STACK_TOP; // Stack pointer.
        end else if (is_new_inst && rd_wen) begin
            regfile[mem_wb.ctrl.wb_addr] <= wb_data;
        end
    end

    assign wb_fwd_wen = is_new_inst && rd_wen;
    assign wb_fwd_rd  = mem_wb.ctrl.wb_addr;

    assign retire_pulse = is_new_inst;
    assign retire_valid = is_new_inst;

    always_comb begin
        retire.pc      = mem_wb.pc;
        retire.inst_id = mem_wb.inst_id;
        retire.rd      = mem_wb.ctrl.wb_addr;
        retire.wen     = rd_wen;
        retire.data    = wb_data;
    end

    // The reserved id would be swallowed by the reset value of the filter.
    a_id_not_reserved: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |-> mem_wb.inst_id != IID_NONE)
        else $error("reserved inst_id reached write-back");

endmodule

`default_nettype wire

// File: verilog/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top import core_pkg::*; #(
    parameter int     DMEM_WORDS = 64,
    parameter u_int_x STACK_TOP  = 32'h00007500
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic issue_valid,
    input  wire uop_t issue_uop,
    output logic      retire_valid,
    output retire_t   retire,
    output u_int_x    instret
);

    u_int_x    regfile [NREGS];
    logic      mem_fwd_wen;
    reg_idx_t  mem_fwd_rd;
    u_int_x    mem_fwd_data;
    logic      wb_fwd_wen;
    reg_idx_t  wb_fwd_rd;
    u_int_x    wb_fwd_data;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    u_int_x    csr_wdata;
    u_int_x    csr_rdata;
    logic      ex_valid;
    ex_mem_t   ex_mem;
    logic      mem_valid;
    mem_wb_t   mem_wb;
    logic      retire_pulse;

    execute_stage u_execute_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .regfile      (regfile),
        .mem_fwd_wen  (mem_fwd_wen),
        .mem_fwd_rd   (mem_fwd_rd),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_wen   (wb_fwd_wen),
        .wb_fwd_rd    (wb_fwd_rd),
        .wb_fwd_data  (wb_fwd_data),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .ex_valid     (ex_valid),
        .ex_mem       (ex_mem)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_mem       (ex_mem),
        .mem_fwd_wen  (mem_fwd_wen),
        .mem_fwd_rd   (mem_fwd_rd),
        .mem_fwd_data (mem_fwd_data),
        .mem_valid    (mem_valid),
        .mem_wb       (mem_wb)
    );

    csr_unit u_csr_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .retire_pulse (retire_pulse),
        .instret      (instret)
    );

    write_back_stage #(
        .STACK_TOP (STACK_TOP)
    ) u_write_back_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .mem_wb       (mem_wb),
        .regfile      (regfile),
        .wb_fwd_wen   (wb_fwd_wen),
        .wb_fwd_rd    (wb_fwd_rd),
        .wb_wdata_out (wb_fwd_data),
        .retire_pulse (retire_pulse),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: sim/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb import core_pkg::*; ();

    typedef struct packed {
        logic [7:0] test;
        logic       valid;
        uop_t       uop;
        logic       expect_ret;
        u_int_x     exp_data;
    } vec_t;

    typedef struct packed {
        logic [7:0] test;
        addr_t      pc;
        iid_t       inst_id;
        reg_idx_t   rd;
        logic       wen;
        u_int_x     data;
    } exp_t;

    logic    clk;
    logic    rst_n;
    logic    issue_valid;
    uop_t    issue_uop;
    logic    retire_valid;
    retire_t retire;
    u_int_x  instret;

    vec_t        vecs [64];
    int          n_vec;
    int          n_tests;
    int          n_ret_total;
    int          n_checked;
    int          errors;
    int          exp_left [16];
    int          test_errs [16];
    exp_t        exp_q [$];
    exp_t        cur_exp;
    logic        loaded;
    logic [31:0] rng_state;

    backend_top u_backend_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .retire_valid (retire_valid),
        .retire       (retire),
        .instret      (instret)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [17];
        logic [7:0]  last_test;
        fd = $fopen("sim/backend_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            errors++;
        end else begin
            last_test = 8'hFF;
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == 8'h23) continue; // Comment or blank.
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                              f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (cnt != 17) continue;
                vecs[n_vec].test              = f[0][7:0];
                vecs[n_vec].valid             = f[1][0];
                vecs[n_vec].uop.inst_id       = f[2][7:0];
                vecs[n_vec].uop.pc            = f[3];
                vecs[n_vec].uop.ctrl.wb_sel   = wb_sel_e'(f[4][1:0]);
                vecs[n_vec].uop.ctrl.rf_wen   = f[5][0];
                vecs[n_vec].uop.ctrl.wb_addr  = f[6][4:0];
                vecs[n_vec].uop.ctrl.alu_op   = alu_op_e'(f[7][3:0]);
                vecs[n_vec].uop.ctrl.mem_op   = mem_op_e'(f[8][1:0]);
                vecs[n_vec].uop.ctrl.csr_op   = csr_op_e'(f[9][1:0]);
                vecs[n_vec].uop.ctrl.src2_imm = f[10][0];
                vecs[n_vec].uop.rs1           = f[11][4:0];
                vecs[n_vec].uop.rs2           = f[12][4:0];
                vecs[n_vec].uop.imm           = f[13];
                vecs[n_vec].uop.csr_addr      = f[14][11:0];
                vecs[n_vec].expect_ret        = f[15][0];
                vecs[n_vec].exp_data          = f[16];
                if (f[0][7:0] != last_test) n_tests++;
                last_test = f[0][7:0];
                if (f[15][0]) exp_left[f[0][3:0]]++;
                n_vec++;
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(input logic [7:0] test, input string name,
                               input u_int_x got, input u_int_x exp);
        assert (got == exp) else begin
            $display("[ERROR] test %0d %s: got %h, expected %h", test, name, got, exp);
            errors++;
            test_errs[test[3:0]]++;
        end
    endtask

    // Retirements come out in issue order.
    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("unexpected retirement of inst_id %h", retire.inst_id);
                errors++;
            end
            if (exp_q.size() != 0) begin
                cur_exp = exp_q.pop_front();
                check_value(cur_exp.test, "retire.pc", retire.pc, cur_exp.pc);
                check_value(cur_exp.test, "retire.inst_id", 32'(retire.inst_id),
                            32'(cur_exp.inst_id));
                check_value(cur_exp.test, "retire.rd", 32'(retire.rd), 32'(cur_exp.rd));
                check_value(cur_exp.test, "retire.wen", 32'(retire.wen), 32'(cur_exp.wen));
                check_value(cur_exp.test, "retire.data", retire.data, cur_exp.data);
                n_checked++;
                exp_left[cur_exp.test[3:0]]--;
                if (exp_left[cur_exp.test[3:0]] == 0) begin
                    $display("test %0d finished with %0d errors", cur_exp.test,
                             test_errs[cur_exp.test[3:0]]);
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #((n_vec + 3 * n_tests + 20) * 20);
        $display("timeout: the run did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int         gap;
        int         wait_cycles;
        logic [7:0] prev_test;
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_uop   = '0;
        loaded      = 1'b0;
        rng_state   = 32'd23813;
        n_vec       = 0;
        n_tests     = 0;
        n_ret_total = 0;
        n_checked   = 0;
        errors      = 0;
        for (int i = 0; i < 16; i++) begin
            exp_left[i]  = 0;
            test_errs[i] = 0;
        end
        load_vectors();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        prev_test = 8'hFF;
        for (int i = 0; i < n_vec; i++) begin
            if (i > 0 && vecs[i].test != prev_test) begin
                gap = int'(next_rand() % 4); // Idle cycles between tests.
                issue_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            prev_test   = vecs[i].test;
            issue_valid = vecs[i].valid;
            issue_uop   = vecs[i].uop;
            if (vecs[i].valid && vecs[i].expect_ret) begin
                exp_q.push_back('{vecs[i].test, vecs[i].uop.pc, vecs[i].uop.inst_id,
                                  vecs[i].uop.ctrl.wb_addr,
                                  vecs[i].uop.ctrl.rf_wen && vecs[i].uop.ctrl.wb_addr != 0,
                                  vecs[i].exp_data});
                n_ret_total++;
            end
            @(negedge clk);
        end
        issue_valid = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        repeat (2) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected retirements never happened", exp_q.size());
            errors++;
        end
        assert (instret == u_int_x'(n_ret_total)) else begin
            $display("[ERROR] instret: got %h, expected %h", instret, n_ret_total);
            errors++;
        end
        $display("%0d tests, %0d retirements checked, %0d errors", n_tests, n_checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/backend_vectors.txt
# test valid id pc wb_sel rf_wen rd alu_op mem_op csr_op src2_imm rs1 rs2 imm csr_addr
# expect_retire exp_data (all hex, register numbers too)
1 1 01 00000100 0 1 05 0 0 0 0 02 00 00000000 000 1 00007500
1 1 02 00000104 0 1 06 0 0 0 0 01 00 00000000 000 1 ffffffff
2 1 03 00000200 0 1 07 a 0 0 1 00 00 12345678 000 1 12345678
2 1 04 00000204 0 1 08 0 0 0 1 07 00 00000011 000 1 12345689
2 1 05 00000208 0 1 09 1 0 0 0 08 07 00000000 000 1 00000011
2 1 06 0000020c 0 1 0a 2 0 0 1 08 00 000000ff 000 1 00000089
2 1 07 00000210 0 1 0b 3 0 0 0 0a 09 00000000 000 1 00000099
2 1 08 00000214 0 1 0c 4 0 0 0 0b 08 00000000 000 1 12345610
2 1 09 00000218 0 1 0d 5 0 0 1 0c 00 00000004 000 1 23456100
2 1 0a 0000021c 0 1 0e 6 0 0 1 06 00 0000001c 000 1 0000000f
2 1 0b 00000220 0 1 0f 7 0 0 0 06 0e 00000000 000 1 ffffffff
2 1 0c 00000224 0 1 10 a 0 0 1 00 00 80000000 000 1 80000000
2 1 0d 00000228 0 1 11 7 0 0 1 10 00 00000004 000 1 f8000000
2 1 0e 0000022c 0 1 12 8 0 0 0 11 0e 00000000 000 1 00000001
2 1 0f 00000230 0 1 13 9 0 0 0 11 0e 00000000 000 1 00000000
2 1 10 00000234 0 1 14 9 0 0 1 0e 00 00000010 000 1 00000001
3 1 11 00000300 0 1 15 a 0 0 1 00 00 00000040 000 1 00000040
3 1 12 00000304 0 0 00 0 2 0 1 15 08 00000008 000 1 00000048
3 1 13 00000308 1 1 16 0 1 0 1 15 00 00000008 000 1 12345689
3 1 14 0000030c 0 1 17 0 0 0 1 16 00 00000001 000 1 1234568a
3 1 15 00000310 0 1 18 0 0 0 1 00 00 00000000 000 1 00000000
3 1 16 00000314 1 1 19 0 1 0 1 15 00 00000008 000 1 12345689
3 1 17 00000318 0 0 00 0 2 0 1 15 17 0000000c 000 1 0000004c
3 1 18 0000031c 0 1 1a 0 0 0 1 00 00 00000005 000 1 00000005
3 1 19 00000320 1 1 1b 0 1 0 1 15 00 0000000c 000 1 1234568a
3 1 1a 00000324 2 1 1c 0 0 0 0 00 00 00000000 000 1 00000328
4 1 1b 00000400 0 1 1d 0 0 0 1 00 00 0000001b 000 1 0000001b
4 1 1b 00000400 0 1 1d 0 0 0 1 00 00 0000001b 000 0 00000000
4 1 1b 00000400 0 1 1d 0 0 0 1 00 00 0000001b 000 0 00000000
5 1 1c 00000500 0 0 00 0 0 2 0 07 00 00000000 340 1 12345678
5 1 1d 00000504 3 1 1e 0 0 1 0 00 00 00000000 340 1 12345678
5 0 00 00000000 0 0 00 0 0 0 0 00 00 00000000 000 0 00000000
5 0 00 00000000 0 0 00 0 0 0 0 00 00 00000000 000 0 00000000
5 0 00 00000000 0 0 00 0 0 0 0 00 00 00000000 000 0 00000000
5 1 1e 00000508 3 1 1f 0 0 1 0 00 00 00000000 c02 1 0000001d

// File: files.f
verilog/core_pkg.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/csr_unit.sv
verilog/write_back_stage.sv
verilog/backend_top.sv
sim/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the backend testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module backend_tb -o backend_sim \
    && ./obj_dir/backend_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && exit 0 || exit 1
